// File: logic/exec_macros.svh
// execute stage constants
// widths, ALU operation codes, branch condition codes
// and the forwarding source encoding
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// data and PC width
`define EXE_WIDTH    16
`define ALUOP_WIDTH  4
`define BRCH_WIDTH   3
`define FWCTRL_WIDTH 5

// ALU operations
`define ALU_ADD   4'h0
`define ALU_AND   4'h1
`define ALU_OR    4'h2
`define ALU_XOR   4'h3
`define ALU_SLL   4'h4
`define ALU_SRL   4'h5
`define ALU_ROL   4'h6
`define ALU_ROR   4'h7
// A shifted up a byte, low byte of B below it
`define ALU_SLBI  4'h8
`define ALU_BTR   4'h9
`define ALU_PASSB 4'hA

// branch and set conditions
`define BR_NEVER  3'd0
`define BR_ALWAYS 3'd1
`define BR_EQ     3'd2
`define BR_NE     3'd3
`define BR_LT     3'd4
`define BR_LE     3'd5
`define BR_GE     3'd6
`define BR_CO     3'd7

// forwarding sources, low two bits of a control word
`define FW_ADDPC 2'b00
`define FW_MEM   2'b01
`define FW_ALU   2'b10
`define FW_IMM8  2'b11

// control word bit positions
`define FW_STAGE_BIT 2
`define FW_EN_BIT    3
`define FW_STORE_BIT 4

`endif

// File: logic/exec_pkg.sv
// execute subsystem types
// plain vectors sized from the shared width macros
`include "exec_macros.svh"

package exec_pkg;

   // data word, also used for every PC value
   typedef logic [`EXE_WIDTH-1:0] word_t;

   typedef logic [`ALUOP_WIDTH-1:0] aluOp_t;

   typedef logic [`BRCH_WIDTH-1:0] brch_t;

   // {store fwd, enable, stage, source[1:0]}
   typedef logic [`FWCTRL_WIDTH-1:0] fwCtrl_t;

endpackage

// File: logic/alu.sv
// 16-bit ALU
// optional operand inversion and carry-in, logic ops, shifts,
// rotates, byte insert and bit reverse, plus the four status flags
`include "exec_macros.svh"

module alu import exec_pkg::*; (
   input  word_t  inA,
   input  word_t  inB,
   input  logic   cin,
   input  logic   invA,
   input  logic   invB,
   input  aluOp_t oper,
   output word_t  result,
   output logic   zero,
   output logic   ofl,
   output logic   cout,
   output logic   signFlag
);

   word_t opA;
   word_t opB;
   word_t reversed;
   logic [3:0] shAmt;
   logic [`EXE_WIDTH:0] addFull;
   logic [2*`EXE_WIDTH-1:0] rolFull;
   logic [2*`EXE_WIDTH-1:0] rorFull;
   logic isAdd;

   // inversion comes first, every op sees the inverted values
   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;
   assign shAmt = opB[3:0];

   // one extra bit holds the carry out
   assign addFull = {1'b0, opA} + {1'b0, opB} + {{`EXE_WIDTH{1'b0}}, cin};

   // rotates work on a doubled copy of A
   assign rolFull = {opA, opA} << shAmt;
   assign rorFull = {opA, opA} >> shAmt;

   always_comb begin
      for (int i = 0; i < `EXE_WIDTH; i++) begin
         reversed[i] = opA[`EXE_WIDTH-1-i];
      end
   end

   always_comb begin
      case (oper)
         `ALU_ADD:   result = addFull[`EXE_WIDTH-1:0];
         `ALU_AND:   result = opA & opB;
         `ALU_OR:    result = opA | opB;
         `ALU_XOR:   result = opA ^ opB;
         `ALU_SLL:   result = opA << shAmt;
         `ALU_SRL:   result = opA >> shAmt;
         `ALU_ROL:   result = rolFull[2*`EXE_WIDTH-1:`EXE_WIDTH];
         `ALU_ROR:   result = rorFull[`EXE_WIDTH-1:0];
         `ALU_SLBI:  result = {opA[7:0], opB[7:0]};
         `ALU_BTR:   result = reversed;
         `ALU_PASSB: result = opB;
         default:    result = '0;
      endcase
   end

   // carry and overflow only mean something on the adder path
   assign isAdd = (oper == `ALU_ADD);
   assign cout = isAdd & addFull[`EXE_WIDTH];
   // same input signs, different result sign
   assign ofl = isAdd & (opA[`EXE_WIDTH-1] == opB[`EXE_WIDTH-1])
                & (addFull[`EXE_WIDTH-1] != opA[`EXE_WIDTH-1]);

   assign zero = (result == '0);
   assign signFlag = result[`EXE_WIDTH-1];

endmodule

// File: logic/branchCond.sv
// branch condition unit
// checks the condition code against the ALU flags, the result
// steers branches and set-on-condition writes
`include "exec_macros.svh"

module branchCond import exec_pkg::*; (
   input  brch_t brchSig,
   input  logic  sf,
   input  logic  zf,
   input  logic  of,
   input  logic  cf,
   output logic  taken
);

   logic lessThan;

   // signed less-than from a subtract
   assign lessThan = sf ^ of;

   always_comb begin
      case (brchSig)
         `BR_NEVER:  taken = 1'b0;
         `BR_ALWAYS: taken = 1'b1;
         `BR_EQ:     taken = zf;
         `BR_NE:     taken = ~zf;
         `BR_LT:     taken = lessThan;
         `BR_LE:     taken = lessThan | zf;
         `BR_GE:     taken = ~lessThan;
         `BR_CO:     taken = cf;
         default:    taken = 1'b0;
      endcase
   end

endmodule

// File: logic/forwardMux.sv
// operand forwarding mux
// picks the register value or one of the EX or MEM stage results
`include "exec_macros.svh"

module forwardMux import exec_pkg::*; (
   input  word_t   regData,
   input  fwCtrl_t fwCtrl,
   input  word_t   x2xAluData,
   input  word_t   x2xImm8Data,
   input  word_t   x2xAddPcData,
   input  word_t   m2xAluData,
   input  word_t   m2xImm8Data,
   input  word_t   m2xMemData,
   input  word_t   m2xAddPcData,
   output word_t   operand
);

   logic [1:0] fwSrc;

   assign fwSrc = fwCtrl[1:0];

   always_comb begin
      operand = regData;
      if (fwCtrl[`FW_EN_BIT]) begin
         if (fwCtrl[`FW_STAGE_BIT]) begin
            // from MEM
            case (fwSrc)
               `FW_ADDPC: operand = m2xAddPcData;
               `FW_MEM:   operand = m2xMemData;
               `FW_ALU:   operand = m2xAluData;
               default:   operand = m2xImm8Data;
            endcase
         end else begin
            // from EX, no memory data exists yet
            case (fwSrc)
               `FW_ADDPC: operand = x2xAddPcData;
               `FW_ALU:   operand = x2xAluData;
               `FW_IMM8:  operand = x2xImm8Data;
               default:   operand = regData;
            endcase
         end
      end
   end

endmodule

// File: logic/execute.sv
// execute stage, purely combinational
// forwards both operands, runs the ALU and condition check,
// forms the branch target, next PC, link value, store data and result
`include "exec_macros.svh"

module execute import exec_pkg::*; (
   input  word_t   incPc,
   input  word_t   inA,
   input  word_t   inB,
   input  word_t   imm8,
   input  word_t   imm11,
   input  word_t   wrtDataIn,
   input  aluOp_t  aluOp,
   input  brch_t   brchSig,
   input  fwCtrl_t fwCtrlA,
   input  fwCtrl_t fwCtrlB,
   input  logic    cin,
   input  logic    invA,
   input  logic    invB,
   input  logic    immSrc,
   input  logic    aluPc,
   input  logic    aluJmp,
   input  logic    jalSel,
   input  logic    setSel,
   input  logic    slbiSel,
   input  logic    stuSel,
   input  word_t   x2xAluData,
   input  word_t   x2xImm8Data,
   input  word_t   x2xAddPcData,
   input  word_t   m2xAluData,
   input  word_t   m2xImm8Data,
   input  word_t   m2xMemData,
   input  word_t   m2xAddPcData,
   output word_t   aluFinal,
   output word_t   aluOut,
   output word_t   newPc,
   output word_t   addPc,
   output word_t   wrtDataOut
);

   word_t fwdAData;
   word_t fwdBData;
   word_t aluInB;
   word_t pcBase;
   word_t pcImm;
   word_t pcTarget;
   word_t jmpPc;
   logic zeroFlag;
   logic oflFlag;
   logic carryFlag;
   logic signFlag;
   logic taken;

   forwardMux fwdA (
      .regData(inA), .fwCtrl(fwCtrlA),
      .x2xAluData(x2xAluData), .x2xImm8Data(x2xImm8Data), .x2xAddPcData(x2xAddPcData),
      .m2xAluData(m2xAluData), .m2xImm8Data(m2xImm8Data), .m2xMemData(m2xMemData),
      .m2xAddPcData(m2xAddPcData), .operand(fwdAData)
   );

   forwardMux fwdB (
      .regData(inB), .fwCtrl(fwCtrlB),
      .x2xAluData(x2xAluData), .x2xImm8Data(x2xImm8Data), .x2xAddPcData(x2xAddPcData),
      .m2xAluData(m2xAluData), .m2xImm8Data(m2xImm8Data), .m2xMemData(m2xMemData),
      .m2xAddPcData(m2xAddPcData), .operand(fwdBData)
   );

   // STU uses the raw B for the address, forwarded B goes to the store
   assign aluInB = stuSel ? inB : fwdBData;
   // forwarded B is store data when the store bit agrees with stuSel
   assign wrtDataOut = (fwCtrlB[`FW_STORE_BIT] == stuSel) ? fwdBData : wrtDataIn;

   alu u_alu (
      .inA(fwdAData), .inB(aluInB), .cin(cin), .invA(invA), .invB(invB), .oper(aluOp),
      .result(aluOut), .zero(zeroFlag), .ofl(oflFlag), .cout(carryFlag),
      .signFlag(signFlag)
   );

   branchCond u_branchCond (
      .brchSig(brchSig), .sf(signFlag), .zf(zeroFlag), .of(oflFlag), .cf(carryFlag),
      .taken(taken)
   );

   // register-relative jumps add to the ALU result
   assign pcBase = aluPc ? aluOut : incPc;
   assign pcImm = immSrc ? imm11 : imm8;
   assign pcTarget = pcBase + pcImm;

   assign jmpPc = taken ? pcTarget : incPc;
   // link value on jal, otherwise the resolved target
   assign addPc = jalSel ? incPc : jmpPc;
   assign newPc = slbiSel ? incPc : (aluJmp ? aluOut : jmpPc);

   // set instructions write the condition as 0 or 1
   assign aluFinal = setSel ? {{(`EXE_WIDTH-1){1'b0}}, taken} : aluOut;

endmodule

// File: logic/exMemLatch.sv
// EX/MEM pipeline register
// one entry with a valid/ready handshake on each side,
// contents hold while the consumer stalls
module exMemLatch import exec_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  inValid,
   output logic  inReady,
   input  word_t aluFinal,
   input  word_t aluOut,
   input  word_t newPc,
   input  word_t addPc,
   input  word_t wrtData,
   input  word_t imm8,
   output logic  outValid,
   input  logic  outReady,
   output word_t aluFinalQ,
   output word_t aluOutQ,
   output word_t newPcQ,
   output word_t addPcQ,
   output word_t wrtDataQ,
   output word_t imm8Q
);

   logic transfer;

   // free when empty or when the current entry leaves this edge
   assign inReady = ~outValid | outReady;
   assign transfer = inValid & inReady;

   always_ff @(posedge clk) begin
      if (rst) begin
         outValid  <= 1'b0;
         aluFinalQ <= '0;
         aluOutQ   <= '0;
         newPcQ    <= '0;
         addPcQ    <= '0;
         wrtDataQ  <= '0;
         imm8Q     <= '0;
      end else begin
         // empties unless a new item replaces the outgoing one
         if (inReady) begin
            outValid <= inValid;
         end
         if (transfer) begin
            aluFinalQ <= aluFinal;
            aluOutQ   <= aluOut;
            newPcQ    <= newPc;
            addPcQ    <= addPc;
            wrtDataQ  <= wrtData;
            imm8Q     <= imm8;
         end
      end
   end

endmodule

// File: logic/exTop.sv
// execute subsystem top
// combinational execute stage feeding the EX/MEM register,
// latched results loop back as EX-to-EX forwarding sources
module exTop import exec_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    inValid,
   output logic    inReady,
   output logic    outValid,
   input  logic    outReady,
   input  word_t   incPc,
   input  word_t   inA,
   input  word_t   inB,
   input  word_t   imm8,
   input  word_t   imm11,
   input  word_t   wrtDataIn,
   input  aluOp_t  aluOp,
   input  brch_t   brchSig,
   input  fwCtrl_t fwCtrlA,
   input  fwCtrl_t fwCtrlB,
   input  logic    cin,
   input  logic    invA,
   input  logic    invB,
   input  logic    immSrc,
   input  logic    aluPc,
   input  logic    aluJmp,
   input  logic    jalSel,
   input  logic    setSel,
   input  logic    slbiSel,
   input  logic    stuSel,
   input  word_t   m2xAluData,
   input  word_t   m2xImm8Data,
   input  word_t   m2xMemData,
   input  word_t   m2xAddPcData,
   output word_t   aluFinalQ,
   output word_t   newPcQ,
   output word_t   addPcQ,
   output word_t   wrtDataQ,
   output word_t   aluOutQ
);

   word_t aluFinal;
   word_t aluOut;
   word_t newPc;
   word_t addPc;
   word_t wrtData;
   word_t imm8Q;

   // EX-to-EX ALU source is the written-back value, set results included
   execute u_execute (
      .incPc(incPc), .inA(inA), .inB(inB), .imm8(imm8), .imm11(imm11),
      .wrtDataIn(wrtDataIn), .aluOp(aluOp), .brchSig(brchSig),
      .fwCtrlA(fwCtrlA), .fwCtrlB(fwCtrlB), .cin(cin), .invA(invA), .invB(invB),
      .immSrc(immSrc), .aluPc(aluPc), .aluJmp(aluJmp), .jalSel(jalSel),
      .setSel(setSel), .slbiSel(slbiSel), .stuSel(stuSel),
      .x2xAluData(aluFinalQ), .x2xImm8Data(imm8Q), .x2xAddPcData(addPcQ),
      .m2xAluData(m2xAluData), .m2xImm8Data(m2xImm8Data), .m2xMemData(m2xMemData),
      .m2xAddPcData(m2xAddPcData),
      .aluFinal(aluFinal), .aluOut(aluOut), .newPc(newPc), .addPc(addPc),
      .wrtDataOut(wrtData)
   );

   exMemLatch u_exMemLatch (
      .clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady),
      .aluFinal(aluFinal), .aluOut(aluOut), .newPc(newPc), .addPc(addPc),
      .wrtData(wrtData), .imm8(imm8), .outValid(outValid), .outReady(outReady),
      .aluFinalQ(aluFinalQ), .aluOutQ(aluOutQ), .newPcQ(newPcQ), .addPcQ(addPcQ),
      .wrtDataQ(wrtDataQ), .imm8Q(imm8Q)
   );

endmodule

// File: testbench/exTop_asserts.sv
// execute subsystem checker bound into the top level
// reference model of forwarding, ALU, conditions and PC selection,
// plus the handshake and hold rules of the EX/MEM register
`include "exec_macros.svh"

module exTop_asserts import exec_pkg::*; (
   input logic    clk,
   input logic    rst,
   input logic    inValid,
   input logic    inReady,
   input logic    outValid,
   input logic    outReady,
   input word_t   incPc, inA, inB, imm8, imm11, wrtDataIn,
   input aluOp_t  aluOp,
   input brch_t   brchSig,
   input fwCtrl_t fwCtrlA, fwCtrlB,
   input logic    cin, invA, invB, immSrc, aluPc, aluJmp,
   input logic    jalSel, setSel, slbiSel, stuSel,
   input word_t   m2xAluData, m2xImm8Data, m2xMemData, m2xAddPcData,
   input word_t   aluFinalQ, newPcQ, addPcQ, wrtDataQ, aluOutQ
);

   timeunit 1ns;
   timeprecision 1ps;

   int errCount = 0;

   word_t fwA, fwB, aluB, opA, opB, res, pcBase, pcTarget, jmpPc;
   logic [`EXE_WIDTH:0] uSum;
   logic signed [`EXE_WIDTH+1:0] sSum;
   logic zf, sf, of, cf, takenM;
   word_t expAluOut, expAluFinal, expNewPc, expAddPc, expWrt, expImm8;
   logic [5*`EXE_WIDTH-1:0] outs, prevOuts;
   logic prevRst, prevXfer, prevStall;

   // operand source as the forwarding control word asks for it
   // EX sources come from the model's own copy of the last result
   function automatic word_t fwdSel(word_t regData, fwCtrl_t c);
      if (!c[`FW_EN_BIT]) return regData;
      if (c[`FW_STAGE_BIT]) begin
         case (c[1:0])
            `FW_ADDPC: return m2xAddPcData;
            `FW_MEM:   return m2xMemData;
            `FW_ALU:   return m2xAluData;
            default:   return m2xImm8Data;
         endcase
      end
      // EX stage has no memory data so the register value stays
      case (c[1:0])
         `FW_ADDPC: return expAddPc;
         `FW_ALU:   return expAluFinal;
         `FW_IMM8:  return expImm8;
         default:   return regData;
      endcase
   endfunction

   // a and b arrive already inverted
   function automatic word_t aluModel(word_t a, word_t b, aluOp_t op, logic c);
      logic [3:0] s;
      word_t rev;
      s = b[3:0];
      rev = {<<{a}};
      case (op)
         `ALU_ADD:   return a + b + word_t'(c);
         `ALU_AND:   return a & b;
         `ALU_OR:    return a | b;
         `ALU_XOR:   return a ^ b;
         `ALU_SLL:   return a << s;
         `ALU_SRL:   return a >> s;
         `ALU_ROL:   return (a << s) | (a >> (`EXE_WIDTH - s));
         `ALU_ROR:   return (a >> s) | (a << (`EXE_WIDTH - s));
         `ALU_SLBI:  return {a[7:0], b[7:0]};
         `ALU_BTR:   return rev;
         `ALU_PASSB: return b;
         default:    return '0;
      endcase
   endfunction

   function automatic logic condModel(brch_t code, logic z, logic s, logic o, logic c);
      case (code)
         `BR_ALWAYS: return 1'b1;
         `BR_EQ:     return z;
         `BR_NE:     return !z;
         `BR_LT:     return s != o;
         `BR_LE:     return (s != o) || z;
         `BR_GE:     return s == o;
         `BR_CO:     return c;
         default:    return 1'b0;
      endcase
   endfunction

   always_comb begin
      fwA = fwdSel(inA, fwCtrlA);
      fwB = fwdSel(inB, fwCtrlB);
      // store address uses raw B
      aluB = stuSel ? inB : fwB;
      opA = invA ? ~fwA : fwA;
      opB = invB ? ~aluB : aluB;
      res = aluModel(opA, opB, aluOp, cin);
      uSum = 17'(opA) + 17'(opB) + 17'(cin);
      sSum = 18'($signed(opA)) + 18'($signed(opB)) + 18'(cin);
      // flags from the true sums
      // carry and overflow only for add
      cf = (aluOp == `ALU_ADD) && uSum[`EXE_WIDTH];
      of = (aluOp == `ALU_ADD) && (sSum > 18'sd32767 || sSum < -18'sd32768);
      zf = (res == '0);
      sf = res[`EXE_WIDTH-1];
      takenM = condModel(brchSig, zf, sf, of, cf);
      pcBase = aluPc ? res : incPc;
      pcTarget = pcBase + (immSrc ? imm11 : imm8);
      jmpPc = takenM ? pcTarget : incPc;
   end

   assign outs = {aluFinalQ, aluOutQ, newPcQ, addPcQ, wrtDataQ};

   // expected results captured on each accepted instruction
   // cleared on reset like the register contents
   always @(posedge clk) begin
      if (rst) begin
         expAluOut <= '0;
         expAluFinal <= '0;
         expNewPc <= '0;
         expAddPc <= '0;
         expWrt <= '0;
         expImm8 <= '0;
      end else if (inValid && inReady) begin
         expAluOut <= res;
         expAluFinal <= setSel ? word_t'(takenM) : res;
         expNewPc <= slbiSel ? incPc : (aluJmp ? res : jmpPc);
         expAddPc <= jalSel ? incPc : jmpPc;
         expWrt <= (fwCtrlB[`FW_STORE_BIT] == stuSel) ? fwB : wrtDataIn;
         expImm8 <= imm8;
      end
      prevRst <= rst;
      prevXfer <= inValid && inReady && !rst;
      prevStall <= outValid && !outReady;
      prevOuts <= outs;
   end

   readyRule: assert property (@(posedge clk) disable iff (rst)
      inReady == (!outValid || outReady))
      else begin
         $error("Error inReady expected %b actual %b",
                $sampled(!outValid || outReady), $sampled(inReady));
         errCount++;
      end

   resetClear: assert property (@(posedge clk) disable iff (rst) prevRst |-> !outValid)
      else begin
         $error("Error outValid after reset expected 0 actual %b", $sampled(outValid));
         errCount++;
      end

   // valid after a transfer or while held and never otherwise
   validRule: assert property (@(posedge clk) disable iff (rst)
      outValid == (prevXfer || prevStall))
      else begin
         $error("Error outValid expected %b actual %b",
                $sampled(prevXfer || prevStall), $sampled(outValid));
         errCount++;
      end

   holdRule: assert property (@(posedge clk) disable iff (rst) prevStall |-> outs == prevOuts)
      else begin
         $error("Error hold expected %h actual %h", $sampled(prevOuts), $sampled(outs));
         errCount++;
      end

   aluOutCheck: assert property (@(posedge clk) disable iff (rst)
      outValid |-> aluOutQ == expAluOut)
      else begin
         $error("Error aluOut expected %h actual %h", $sampled(expAluOut), $sampled(aluOutQ));
         errCount++;
      end

   aluFinalCheck: assert property (@(posedge clk) disable iff (rst)
      outValid |-> aluFinalQ == expAluFinal)
      else begin
         $error("Error aluFinal expected %h actual %h",
                $sampled(expAluFinal), $sampled(aluFinalQ));
         errCount++;
      end

   newPcCheck: assert property (@(posedge clk) disable iff (rst)
      outValid |-> newPcQ == expNewPc)
      else begin
         $error("Error newPc expected %h actual %h", $sampled(expNewPc), $sampled(newPcQ));
         errCount++;
      end

   addPcCheck: assert property (@(posedge clk) disable iff (rst)
      outValid |-> addPcQ == expAddPc)
      else begin
         $error("Error addPc expected %h actual %h", $sampled(expAddPc), $sampled(addPcQ));
         errCount++;
      end

   wrtDataCheck: assert property (@(posedge clk) disable iff (rst)
      outValid |-> wrtDataQ == expWrt)
      else begin
         $error("Error wrtData expected %h actual %h", $sampled(expWrt), $sampled(wrtDataQ));
         errCount++;
      end

endmodule

bind exTop exTop_asserts u_asserts (.*);

// File: testbench/tb_exTop.sv
// testbench for the execute subsystem
// random instructions and forwarding controls, random stall bursts
// on the consumer side, the bound checker compares every result
module tb_exTop import exec_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_XFERS = 300;
   localparam int XFER_TIMEOUT = 5000;
   localparam int DRAIN_TIMEOUT = 50;

   logic clk, rst, inValid, inReady, outValid, outReady;
   word_t incPc, inA, inB, imm8, imm11, wrtDataIn;
   aluOp_t aluOp;
   brch_t brchSig;
   fwCtrl_t fwCtrlA, fwCtrlB;
   logic cin, invA, invB, immSrc, aluPc, aluJmp, jalSel, setSel, slbiSel, stuSel;
   word_t m2xAluData, m2xImm8Data, m2xMemData, m2xAddPcData;
   word_t aluFinalQ, newPcQ, addPcQ, wrtDataQ, aluOutQ;
   integer seed = 32'heeedc87a;
   int xfers;
   int cycles;
   int stallLeft;

   exTop u_exTop (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic failRun(input string why);
      $display("sim failed");
      $fatal(1, "%s", why);
   endtask

   // one random instruction, valid about three times in four
   task automatic driveInstr();
      logic [31:0] r;
      r = $random(seed);
      inValid = r[0] | r[1];
      cin = r[2];
      invA = r[3];
      invB = r[4];
      immSrc = r[5];
      aluPc = r[6];
      aluJmp = r[7];
      jalSel = r[8];
      setSel = r[9];
      slbiSel = r[10];
      stuSel = r[11];
      brchSig = r[14:12];
      fwCtrlA = r[19:15];
      fwCtrlB = r[24:20];
      aluOp = aluOp_t'(r[31:25] % 11);
      {incPc, inA} = $random(seed);
      {inB, imm8} = $random(seed);
      {imm11, wrtDataIn} = $random(seed);
      {m2xAluData, m2xImm8Data} = $random(seed);
      {m2xMemData, m2xAddPcData} = $random(seed);
   endtask

   // consumer ready with occasional stall bursts
   task automatic driveReady();
      logic [31:0] r;
      r = $random(seed);
      if (stallLeft > 0) begin
         stallLeft--;
         outReady = 1'b0;
      end else if (r[2:0] == 3'd0) begin
         stallLeft = int'(r[5:3]);
         outReady = 1'b0;
      end else begin
         outReady = 1'b1;
      end
   endtask

   // the first assertion failure ends the run
   initial begin
      forever begin
         @(negedge clk);
         if (u_exTop.u_asserts.errCount != 0) begin
            failRun("an assertion check failed");
         end
      end
   end

   initial begin
      rst = 1'b1;
      inValid = 1'b0;
      outReady = 1'b0;
      {incPc, inA, inB, imm8, imm11, wrtDataIn} = '0;
      {aluOp, brchSig, fwCtrlA, fwCtrlB} = '0;
      {cin, invA, invB, immSrc, aluPc, aluJmp, jalSel, setSel, slbiSel, stuSel} = '0;
      {m2xAluData, m2xImm8Data, m2xMemData, m2xAddPcData} = '0;
      xfers = 0;
      cycles = 0;
      stallLeft = 0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      while (xfers < NUM_XFERS) begin
         if (cycles >= XFER_TIMEOUT) begin
            failRun("timeout waiting for all transfers to be accepted");
         end
         driveInstr();
         driveReady();
         // count at the falling edge where the handshake is settled
         @(negedge clk);
         if (inValid && inReady) begin
            xfers++;
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      // stop issuing and let the last result leave
      inValid = 1'b0;
      outReady = 1'b1;
      cycles = 0;
      while (outValid) begin
         if (cycles >= DRAIN_TIMEOUT) begin
            failRun("timeout waiting for the output register to drain");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
      @(posedge clk);
      #1;
      if (u_exTop.u_asserts.errCount == 0) begin
         $display("sim passed");
         $finish;
      end else begin
         failRun("assertion checks failed");
      end
   end

endmodule

// File: vlog.f
+incdir+logic
logic/exec_pkg.sv
logic/alu.sv
logic/branchCond.sv
logic/forwardMux.sv
logic/execute.sv
logic/exMemLatch.sv
logic/exTop.sv
testbench/exTop_asserts.sv
testbench/tb_exTop.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exTop
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)
